// ==== src/sdram_ctrl_macros.svh ====
`ifndef SDRAM_CTRL_MACROS_SVH
`define SDRAM_CTRL_MACROS_SVH

// Address field widths --------------------
`define SDRAM_ROW_W  14
`define SDRAM_BANK_W 3
`define SDRAM_COL_W  9
`define SDRAM_PAGE_W 17                    // Row and bank together
`define SDRAM_MASK_W 4

// Command codes --------------------
`define SDRAM_CMD_NOOP 3'b111
`define SDRAM_CMD_ACTV 3'b011              // Row open
`define SDRAM_CMD_READ 3'b101
`define SDRAM_CMD_WRTE 3'b100
`define SDRAM_CMD_PRCH 3'b010              // Row close
`define SDRAM_CMD_ARSR 3'b001              // Auto refresh

// Minimum clocks from a command to the next one
`define SDRAM_GAP_ARSR  13
`define SDRAM_GAP_ACTV  4
`define SDRAM_GAP_WRTE  6
`define SDRAM_GAP_OTHER 5

// A10 high selects all banks
`define SDRAM_PRCH_ALL_ADDR 14'h0400

// Clocks after ACTIVATE before PRECHARGE is allowed
`define SDRAM_ACTV_TIMEOUT 4

`endif

// ==== src/sdram_ctrl_pkg.sv ====
`include "sdram_ctrl_macros.svh"

package sdram_ctrl_pkg;

  typedef enum logic [2:0] {
    CMD_NOOP = `SDRAM_CMD_NOOP,
    CMD_ACTV = `SDRAM_CMD_ACTV,
    CMD_READ = `SDRAM_CMD_READ,
    CMD_WRTE = `SDRAM_CMD_WRTE,
    CMD_PRCH = `SDRAM_CMD_PRCH,
    CMD_ARSR = `SDRAM_CMD_ARSR
  } sdram_cmd_e;

  // Two views of the same client address --------------------
  typedef struct packed {
    logic [`SDRAM_ROW_W-1:0]  row;
    logic [`SDRAM_BANK_W-1:0] bank;
    logic [`SDRAM_COL_W-1:0]  col;
  } addr_rbc_s;

  typedef struct packed {
    logic [`SDRAM_PAGE_W-1:0] page;
    logic [`SDRAM_COL_W-1:0]  col;
  } addr_pc_s;

  typedef union packed {
    addr_rbc_s rbc;                        // Command address
    addr_pc_s  pc;                         // Page compare
  } mem_addr_u;

  typedef struct packed {
    logic                     valid;
    logic                     write;
    mem_addr_u                addr;
    logic [`SDRAM_MASK_W-1:0] mask;
  } port_req_s;

  typedef struct packed {
    logic                     page_active;
    logic [`SDRAM_PAGE_W-1:0] open_page;
    logic                     last_was_write;
    logic                     refresh_pending;   // Refreshed with no row opened since
  } bank_state_s;

endpackage

// ==== src/request_capture.sv ====
`timescale 1ns/1ps
`include "sdram_ctrl_macros.svh"

module request_capture (
  input  logic                                  INPUT_CLK,
  input  logic                                  RST,
  input  logic                                  req_valid,
  input  logic                                  req_write,
  input  logic [`SDRAM_PAGE_W+`SDRAM_COL_W-1:0] req_addr,
  input  logic [`SDRAM_MASK_W-1:0]              req_mask,
  input  logic                                  refresh_strobe,
  input  logic                                  refresh_ack,
  input  sdram_ctrl_pkg::bank_state_s           bank,
  output sdram_ctrl_pkg::port_req_s             captured,
  output logic                                  page_hit,
  output logic                                  refresh_pending
);
  import sdram_ctrl_pkg::*;

  mem_addr_u                live_addr;
  mem_addr_u                addr_q;
  logic                     valid_q;
  logic                     write_q;
  logic [`SDRAM_MASK_W-1:0] mask_q;
  logic                     strobe_q;

  assign live_addr = req_addr;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      valid_q  <= 1'b0;
      page_hit <= 1'b0;
      strobe_q <= 1'b0;
    end
    else
    begin
      valid_q  <= req_valid;
      strobe_q <= refresh_strobe;
      page_hit <= bank.page_active && !bank.refresh_pending && !refresh_pending &&
                  (live_addr.pc.page == bank.open_page);   // Same cycle as captured
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    write_q <= req_write;
    addr_q  <= live_addr;
    mask_q  <= req_mask;
  end

  // One outstanding refresh per strobe toggle
  assign refresh_pending = strobe_q ^ refresh_ack;
  assign captured = '{valid: valid_q, write: write_q, addr: addr_q, mask: mask_q};

endmodule

// ==== src/bank_state_tracker.sv ====
`timescale 1ns/1ps
`include "sdram_ctrl_macros.svh"

module bank_state_tracker (
  input  logic                        INPUT_CLK,
  input  logic                        RST,
  input  sdram_ctrl_pkg::sdram_cmd_e  issued_cmd,
  input  sdram_ctrl_pkg::port_req_s   captured,
  output sdram_ctrl_pkg::bank_state_s bank,
  output logic                        refresh_ack
);
  import sdram_ctrl_pkg::*;

  logic                     page_active_q;
  logic [`SDRAM_PAGE_W-1:0] open_page_q;
  logic                     last_write_q;
  logic                     refreshed_q;
  logic                     ack_q;

  // Control state --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      page_active_q <= 1'b0;
      last_write_q  <= 1'b0;
      refreshed_q   <= 1'b0;
      ack_q         <= 1'b0;
    end
    else
    begin
      case (issued_cmd)
        CMD_ACTV:
        begin
          page_active_q <= 1'b1;
          refreshed_q   <= 1'b0;
        end
        CMD_PRCH: page_active_q <= 1'b0;
        CMD_ARSR:
        begin
          refreshed_q <= 1'b1;
          ack_q       <= ~ack_q;           // Now equals the strobe level
        end
        default: ;
      endcase
      if (issued_cmd != CMD_NOOP)
        last_write_q <= (issued_cmd == CMD_WRTE);
    end
  end

  // Page tag is only meaningful while page_active_q
  always_ff @(posedge INPUT_CLK)
  begin
    if (issued_cmd == CMD_ACTV)
      open_page_q <= captured.addr.pc.page;
  end

  assign bank = '{
    page_active:     page_active_q,
    open_page:       open_page_q,
    last_was_write:  last_write_q,
    refresh_pending: refreshed_q
  };
  assign refresh_ack = ack_q;

endmodule

// ==== src/timing_counter.sv ====
`timescale 1ns/1ps
`include "sdram_ctrl_macros.svh"

module timing_counter (
  input  logic                       INPUT_CLK,
  input  logic                       RST,
  input  sdram_ctrl_pkg::sdram_cmd_e issued_cmd,
  output logic                       may_issue,
  output logic                       row_may_close
);
  import sdram_ctrl_pkg::*;

  logic [3:0] gap_cnt;
  logic [2:0] actv_cnt;

  // Command spacing --------------------
  // Loaded one clock after the command shows and reaches zero one clock
  // before the earliest next command
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      gap_cnt <= 4'd0;
    else
    begin
      case (issued_cmd)
        CMD_NOOP:
        begin
          if (gap_cnt != 4'd0)
            gap_cnt <= gap_cnt - 4'd1;
        end
        CMD_ARSR: gap_cnt <= 4'(`SDRAM_GAP_ARSR - 2);
        CMD_ACTV: gap_cnt <= 4'(`SDRAM_GAP_ACTV - 2);
        CMD_WRTE: gap_cnt <= 4'(`SDRAM_GAP_WRTE - 2);
        default:  gap_cnt <= 4'(`SDRAM_GAP_OTHER - 2);
      endcase
    end
  end

  // Row open time --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      actv_cnt <= 3'(`SDRAM_ACTV_TIMEOUT);
    else if (issued_cmd == CMD_ACTV)
      actv_cnt <= 3'd1;                    // Clocks since ACTIVATE
    else if (actv_cnt != 3'(`SDRAM_ACTV_TIMEOUT))
      actv_cnt <= actv_cnt + 3'd1;         // Saturates
  end

  assign may_issue     = (gap_cnt == 4'd0);
  assign row_may_close = (actv_cnt == 3'(`SDRAM_ACTV_TIMEOUT));

endmodule

// ==== src/command_issuer.sv ====
`timescale 1ns/1ps
`include "sdram_ctrl_macros.svh"

module command_issuer (
  input  logic                        INPUT_CLK,
  input  logic                        RST,
  input  sdram_ctrl_pkg::port_req_s   captured,
  input  logic                        page_hit,
  input  logic                        refresh_pending,
  input  sdram_ctrl_pkg::bank_state_s bank,
  input  logic                        may_issue,
  input  logic                        row_may_close,
  output sdram_ctrl_pkg::sdram_cmd_e  issued_cmd,
  output sdram_ctrl_pkg::sdram_cmd_e  cmd,
  output logic [`SDRAM_ROW_W-1:0]     cmd_addr,
  output logic [`SDRAM_BANK_W-1:0]    cmd_bank,
  output logic [`SDRAM_MASK_W-1:0]    cmd_mask,
  output logic                        grant
);
  import sdram_ctrl_pkg::*;

  sdram_cmd_e              next_cmd;
  sdram_cmd_e              cmd_q;
  logic                    issue_ok;
  logic                    prch_ok;
  logic                    is_rw;
  logic                    may_issue_q;
  logic [`SDRAM_ROW_W-1:0] next_addr;

  assign issue_ok = may_issue && (cmd_q == CMD_NOOP);   // Forced NOOP after a command
  // One more clock of write recovery before closing the row
  assign prch_ok  = row_may_close && (!bank.last_was_write || may_issue_q);
  assign is_rw    = (next_cmd == CMD_READ) || (next_cmd == CMD_WRTE);

  // Next command --------------------
  always_comb
  begin
    next_cmd = CMD_NOOP;
    if (captured.valid && page_hit)
      next_cmd = captured.write ? CMD_WRTE : CMD_READ;
    else if (bank.page_active && (refresh_pending || captured.valid) && prch_ok)
      next_cmd = CMD_PRCH;
    else if (!bank.page_active && refresh_pending)
      next_cmd = CMD_ARSR;
    else if (!bank.page_active && captured.valid)
      next_cmd = CMD_ACTV;
  end

  always_comb
  begin
    case (next_cmd)
      CMD_READ, CMD_WRTE:
        next_addr = {{(`SDRAM_ROW_W-`SDRAM_COL_W-1){1'b0}}, captured.addr.rbc.col, 1'b0};
      CMD_PRCH: next_addr = `SDRAM_PRCH_ALL_ADDR;
      default:  next_addr = captured.addr.rbc.row;
    endcase
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      cmd_q       <= CMD_NOOP;
      grant       <= 1'b0;
      cmd_mask    <= '0;
      may_issue_q <= 1'b0;
    end
    else
    begin
      may_issue_q <= may_issue;
      cmd_q       <= issue_ok ? next_cmd : CMD_NOOP;
      grant       <= issue_ok && is_rw;
      if (issue_ok && is_rw)
        cmd_mask <= captured.mask;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue_ok && (next_cmd != CMD_NOOP))
      cmd_addr <= next_addr;
    if (issue_ok && (is_rw || (next_cmd == CMD_ACTV)))
      cmd_bank <= captured.addr.rbc.bank;  // PRECHARGE ALL keeps it
  end

  assign cmd        = cmd_q;
  assign issued_cmd = cmd_q;

endmodule

// ==== src/sdram_ctrl_top.sv ====
`timescale 1ns/1ps
`include "sdram_ctrl_macros.svh"

module sdram_ctrl_top (
  input  logic                                  INPUT_CLK,
  input  logic                                  RST,
  input  logic                                  refresh_strobe,
  input  logic                                  req_valid,
  input  logic                                  req_write,
  input  logic [`SDRAM_PAGE_W+`SDRAM_COL_W-1:0] req_addr,
  input  logic [`SDRAM_MASK_W-1:0]              req_mask,
  output sdram_ctrl_pkg::sdram_cmd_e            cmd,
  output logic [`SDRAM_ROW_W-1:0]               cmd_addr,
  output logic [`SDRAM_BANK_W-1:0]              cmd_bank,
  output logic [`SDRAM_MASK_W-1:0]              cmd_mask,
  output logic                                  grant
);
  import sdram_ctrl_pkg::*;

  port_req_s   captured;
  bank_state_s bank;
  sdram_cmd_e  issued_cmd;
  logic        page_hit;
  logic        refresh_pending;
  logic        refresh_ack;
  logic        may_issue;
  logic        row_may_close;

  request_capture request_capture_inst (
    .INPUT_CLK       (INPUT_CLK),
    .RST             (RST),
    .req_valid       (req_valid),
    .req_write       (req_write),
    .req_addr        (req_addr),
    .req_mask        (req_mask),
    .refresh_strobe  (refresh_strobe),
    .refresh_ack     (refresh_ack),
    .bank            (bank),
    .captured        (captured),
    .page_hit        (page_hit),
    .refresh_pending (refresh_pending)
  );

  bank_state_tracker bank_state_tracker_inst (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .issued_cmd  (issued_cmd),
    .captured    (captured),
    .bank        (bank),
    .refresh_ack (refresh_ack)
  );

  timing_counter timing_counter_inst (
    .INPUT_CLK     (INPUT_CLK),
    .RST           (RST),
    .issued_cmd    (issued_cmd),
    .may_issue     (may_issue),
    .row_may_close (row_may_close)
  );

  command_issuer command_issuer_inst (
    .INPUT_CLK       (INPUT_CLK),
    .RST             (RST),
    .captured        (captured),
    .page_hit        (page_hit),
    .refresh_pending (refresh_pending),
    .bank            (bank),
    .may_issue       (may_issue),
    .row_may_close   (row_may_close),
    .issued_cmd      (issued_cmd),
    .cmd             (cmd),
    .cmd_addr        (cmd_addr),
    .cmd_bank        (cmd_bank),
    .cmd_mask        (cmd_mask),
    .grant           (grant)
  );

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
  output logic INPUT_CLK,
  output logic RST
);

  initial
  begin
    INPUT_CLK = 1'b0;
    forever #2 INPUT_CLK = ~INPUT_CLK;     // 4 ns period
  end

  initial
  begin
    RST = 1'b1;
    repeat (3) @(posedge INPUT_CLK);
    @(negedge INPUT_CLK);
    RST = 1'b0;
  end

endmodule

// ==== testbench/sdram_ctrl_checker.sv ====
`timescale 1ns/1ps
`include "sdram_ctrl_macros.svh"

module sdram_ctrl_checker (
  input logic                       INPUT_CLK,
  input logic                       RST,
  input logic                       req_valid,
  input logic                       refresh_strobe,
  input sdram_ctrl_pkg::sdram_cmd_e cmd,
  input logic [`SDRAM_MASK_W-1:0]   cmd_mask,
  input logic                       grant
);
  import sdram_ctrl_pkg::*;

  int unsigned fail_count = 0;
  logic        active_seen;                // Any request or refresh so far
  logic [3:0]  since_cmd;                  // Saturating clocks since last command
  logic [3:0]  last_gap;

  function automatic logic [3:0] gap_after(input sdram_cmd_e c);
    case (c)
      CMD_ARSR: gap_after = 4'(`SDRAM_GAP_ARSR);
      CMD_ACTV: gap_after = 4'(`SDRAM_GAP_ACTV);
      CMD_WRTE: gap_after = 4'(`SDRAM_GAP_WRTE);
      default:  gap_after = 4'(`SDRAM_GAP_OTHER);
    endcase
  endfunction

  always @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      active_seen <= 1'b0;
      since_cmd   <= 4'hf;
      last_gap    <= 4'd0;
    end
    else
    begin
      if (req_valid || refresh_strobe)
        active_seen <= 1'b1;
      if (cmd != CMD_NOOP)
      begin
        since_cmd <= 4'd1;
        last_gap  <= gap_after(cmd);
      end
      else if (since_cmd != 4'hf)
        since_cmd <= since_cmd + 4'd1;
    end
  end

  // Properties --------------------
  idle_after_reset: assert property (@(posedge INPUT_CLK) disable iff (RST)
    !active_seen |-> (cmd == CMD_NOOP) && !grant && (cmd_mask == '0))
    else begin fail_count++; $error("Output not idle before first request"); end

  noop_after_cmd: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (cmd != CMD_NOOP) |=> (cmd == CMD_NOOP))
    else begin fail_count++; $error("Command not followed by NOOP"); end

  cmd_spacing: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (cmd != CMD_NOOP) |-> (since_cmd >= last_gap))
    else begin fail_count++; $error("Command gap too short"); end

  grant_on_access: assert property (@(posedge INPUT_CLK) disable iff (RST)
    grant |-> ((cmd == CMD_READ) || (cmd == CMD_WRTE)) && req_valid)
    else begin fail_count++; $error("Grant outside an access"); end

endmodule

bind sdram_ctrl_top sdram_ctrl_checker sdram_ctrl_checker_inst (
  .INPUT_CLK      (INPUT_CLK),
  .RST            (RST),
  .req_valid      (req_valid),
  .refresh_strobe (refresh_strobe),
  .cmd            (cmd),
  .cmd_mask       (cmd_mask),
  .grant          (grant)
);

// ==== testbench/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps
`include "sdram_ctrl_macros.svh"

module tb_sdram_ctrl;
  import sdram_ctrl_pkg::*;

  localparam int CMD_TIMEOUT = 64;         // Clocks allowed per expected command

  logic                                  INPUT_CLK;
  logic                                  RST;
  logic                                  refresh_strobe;
  logic                                  req_valid;
  logic                                  req_write;
  logic [`SDRAM_PAGE_W+`SDRAM_COL_W-1:0] req_addr;
  logic [`SDRAM_MASK_W-1:0]              req_mask;
  sdram_cmd_e                            cmd;
  logic [`SDRAM_ROW_W-1:0]               cmd_addr;
  logic [`SDRAM_BANK_W-1:0]              cmd_bank;
  logic [`SDRAM_MASK_W-1:0]              cmd_mask;
  logic                                  grant;

  logic                     page_open;     // Reference model of the open page
  logic [`SDRAM_PAGE_W-1:0] open_page;

  clock_gen clock_gen_inst (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST)
  );

  sdram_ctrl_top sdram_ctrl_top_inst (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .req_mask       (req_mask),
    .cmd            (cmd),
    .cmd_addr       (cmd_addr),
    .cmd_bank       (cmd_bank),
    .cmd_mask       (cmd_mask),
    .grant          (grant)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("** Error at %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      abort_run("Value mismatch");
    end
  endtask

  always @(negedge INPUT_CLK)
  begin
    assert (sdram_ctrl_top_inst.sdram_ctrl_checker_inst.fail_count == 0)
    else abort_run("A protocol assertion in sdram_ctrl_checker failed");
  end

  // Stimulus helpers --------------------
  function automatic mem_addr_u make_addr(input logic [`SDRAM_ROW_W-1:0] row,
                                          input logic [`SDRAM_BANK_W-1:0] bank,
                                          input logic [`SDRAM_COL_W-1:0] col);
    mem_addr_u a;
    a.rbc.row  = row;
    a.rbc.bank = bank;
    a.rbc.col  = col;
    return a;
  endfunction

  task automatic wait_cmd(output sdram_cmd_e seen);
    int n;
    n = 0;
    seen = CMD_NOOP;
    while (seen == CMD_NOOP)
    begin
      @(negedge INPUT_CLK);
      seen = cmd;
      n++;
      if (n > CMD_TIMEOUT)
        abort_run("Timeout waiting for a command on cmd");
    end
  endtask

  task automatic expect_idle(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge INPUT_CLK);
      check_value("cmd", 32'(CMD_NOOP), 32'(cmd));
    end
  endtask

  task automatic access(input mem_addr_u a, input logic wr, input logic [3:0] mask);
    sdram_cmd_e c;
    req_addr  = a;
    req_write = wr;
    req_mask  = mask;
    req_valid = 1'b1;
    if (page_open && (open_page != a.pc.page))
    begin
      wait_cmd(c);                         // Page miss closes the row
      check_value("cmd", 32'(CMD_PRCH), 32'(c));
      check_value("cmd_addr", 32'(`SDRAM_PRCH_ALL_ADDR), 32'(cmd_addr));
      page_open = 1'b0;
    end
    if (!page_open)
    begin
      wait_cmd(c);
      check_value("cmd", 32'(CMD_ACTV), 32'(c));
      check_value("cmd_addr", 32'(a.rbc.row), 32'(cmd_addr));
      check_value("cmd_bank", 32'(a.rbc.bank), 32'(cmd_bank));
      page_open = 1'b1;
      open_page = a.pc.page;
    end
    wait_cmd(c);
    check_value("cmd", 32'(wr ? CMD_WRTE : CMD_READ), 32'(c));
    check_value("cmd_addr", 32'({a.rbc.col, 1'b0}), 32'(cmd_addr));
    check_value("cmd_bank", 32'(a.rbc.bank), 32'(cmd_bank));
    check_value("grant", 32'd1, 32'(grant));
    if (wr)
      check_value("cmd_mask", 32'(mask), 32'(cmd_mask));
    @(negedge INPUT_CLK);
    req_valid = 1'b0;                      // Held through the grant cycle
  endtask

  task automatic refresh_once;
    sdram_cmd_e c;
    refresh_strobe = ~refresh_strobe;
    if (page_open)
    begin
      wait_cmd(c);
      check_value("cmd", 32'(CMD_PRCH), 32'(c));
      check_value("cmd_addr", 32'(`SDRAM_PRCH_ALL_ADDR), 32'(cmd_addr));
      page_open = 1'b0;
    end
    wait_cmd(c);
    check_value("cmd", 32'(CMD_ARSR), 32'(c));
    expect_idle(2 * `SDRAM_GAP_ARSR);      // Only one refresh per toggle
  endtask

  task automatic random_access;
    mem_addr_u a;
    a = make_addr(14'($urandom_range(1, 0)), 3'($urandom_range(1, 0)), 9'($urandom));
    access(a, 1'($urandom), 4'($urandom));
  endtask

  // Sequence --------------------
  initial
  begin
    int waited;
    refresh_strobe = 1'b0;
    req_valid      = 1'b0;
    req_write      = 1'b0;
    req_addr       = '0;
    req_mask       = '0;
    page_open      = 1'b0;
    open_page      = '0;
    void'($urandom(32'hfc3ea4c0));
    waited = 0;
    while (RST !== 1'b0)
    begin
      @(negedge INPUT_CLK);
      waited++;
      if (waited > CMD_TIMEOUT)
        abort_run("Timeout waiting for reset release");
    end
    expect_idle(8);
    access(make_addr(14'h0005, 3'd2, 9'h1a3), 1'b1, 4'ha);   // Closed bank
    access(make_addr(14'h0005, 3'd2, 9'h044), 1'b0, 4'h3);   // Page hit
    access(make_addr(14'h0011, 3'd2, 9'h0ff), 1'b0, 4'h5);   // Row miss
    access(make_addr(14'h0011, 3'd6, 9'h010), 1'b1, 4'h9);   // Bank miss
    refresh_once;
    refresh_once;                          // Page already closed
    access(make_addr(14'h0011, 3'd6, 9'h011), 1'b0, 4'h0);
    for (int i = 0; i < 40; i++)
    begin
      random_access();
      if ((i % 8) == 7)
        refresh_once;
    end
    if (sdram_ctrl_top_inst.sdram_ctrl_checker_inst.fail_count == 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
      abort_run("A protocol assertion in sdram_ctrl_checker failed");
  end

endmodule

// ==== build.f ====
+incdir+src
src/sdram_ctrl_pkg.sv
src/request_capture.sv
src/bank_state_tracker.sv
src/timing_counter.sv
src/command_issuer.sv
src/sdram_ctrl_top.sv
testbench/clock_gen.sv
testbench/sdram_ctrl_checker.sv
testbench/tb_sdram_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timing
TOP       = tb_sdram_ctrl
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
